//--- l2_cache_params.svh
// L2 and L1 cache geometry macros: set and way counts, address, tag and way widths
`ifndef L2_CACHE_PARAMS_SVH
`define L2_CACHE_PARAMS_SVH

// L2 organization, 16 sets of 4 ways
`define L2_NUM_SETS 16
`define L2_NUM_WAYS 4

// The set index is the low part of the line address
`define L2_SET_INDEX_WIDTH 4

// Line address, byte offset already removed
`define L2_ADDR_WIDTH 26

// Everything above the set index is the L2 tag
`define L2_TAG_WIDTH 22

// L1 geometry as seen from the L2 directory.
// The L1 tag is the line address above the L1 set index
`define L1_SET_INDEX_WIDTH 6
`define L1_TAG_WIDTH 20
`define L1_WAY_WIDTH 2

`endif

//--- l2_request_pkg.sv
// Request op enum, unit/strand/address types, and request, response, writeback and L1 update structs
`default_nettype none

`include "l2_cache_params.svh"

package l2_request_pkg;

	// Encodings follow the core-side request interface
	typedef enum logic [2:0]
	{
		pci_load = 3'd0,
		pci_store = 3'd1,
		pci_load_sync = 3'd4,
		pci_store_sync = 3'd5
	} pci_op_t;

	typedef logic [1:0] unit_t;
	typedef logic [1:0] strand_t;
	typedef logic [`L2_ADDR_WIDTH - 1:0] line_addr_t;

	// A fill arrives as an ordinary request with has_fill set
	typedef struct packed
	{
		logic valid;
		unit_t unit;
		strand_t strand;
		pci_op_t op;
		logic [`L1_WAY_WIDTH - 1:0] l1_way;
		line_addr_t address;
		logic has_fill;
	} l2_request_t;

	typedef struct packed
	{
		logic valid;
		unit_t unit;
		strand_t strand;
		pci_op_t op;
		logic hit;
		logic [$clog2(`L2_NUM_WAYS) - 1:0] way;
	} l2_response_t;

	typedef struct packed
	{
		logic valid;
		line_addr_t address;
	} writeback_t;

	// Tells the L1 which of its lines holds data that was just stored to
	typedef struct packed
	{
		logic valid;
		logic [`L1_WAY_WIDTH - 1:0] l1_way;
		logic [`L1_TAG_WIDTH - 1:0] l1_tag;
	} l1_update_t;

endpackage

`default_nettype wire

//--- l2_dir_pkg.sv
// L2 tag, way, set and L1 directory types, plus the tag and directory stage structs
`default_nettype none

`include "l2_cache_params.svh"

package l2_dir_pkg;

	typedef logic [`L2_TAG_WIDTH - 1:0] l2_tag_t;
	typedef logic [$clog2(`L2_NUM_WAYS) - 1:0] l2_way_t;
	typedef logic [`L2_SET_INDEX_WIDTH - 1:0] l2_set_t;
	typedef logic [`L1_TAG_WIDTH - 1:0] l1_tag_t;

	// One entry per L2 line, for the single core
	typedef struct packed
	{
		logic valid;
		logic [`L1_WAY_WIDTH - 1:0] way;
		l1_tag_t tag;
	} l1_dir_entry_t;

	typedef struct packed
	{
		l2_request_pkg::l2_request_t request;
		l2_tag_t [`L2_NUM_WAYS - 1:0] way_tags;
		logic [`L2_NUM_WAYS - 1:0] way_valid;
		l2_way_t replace_way;
	} tag_stage_t;

	// Dirty bits and the L1 entry are the values from before this request's update
	typedef struct packed
	{
		l2_request_pkg::l2_request_t request;
		logic hit;
		l2_way_t hit_way;
		l2_way_t replace_way;
		l2_tag_t replace_tag;
		logic replace_valid;
		logic [`L2_NUM_WAYS - 1:0] dirty;
		l1_dir_entry_t l1_entry;
	} dir_stage_t;

endpackage

`default_nettype wire

//--- l2_cache_tag.sv
// L2 tag stage: tag array lookup, per-set round-robin replacement and fill install
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_params.svh"

module l2_cache_tag (
	input logic clk,
	input logic reset,
	input logic stall,
	input l2_request_pkg::l2_request_t request,
	output l2_dir_pkg::tag_stage_t tag_out
);

	// All ways of a set are read together, so each set is one packed row
	l2_dir_pkg::l2_tag_t [`L2_NUM_WAYS - 1:0] tag_mem [`L2_NUM_SETS];
	logic [`L2_NUM_WAYS - 1:0] valid_mem [`L2_NUM_SETS];
	l2_dir_pkg::l2_way_t replace_ptr [`L2_NUM_SETS];

	l2_dir_pkg::l2_set_t request_set;
	l2_dir_pkg::l2_tag_t request_tag;
	logic fill_en;
	logic tag_present;

	assign request_set = request.address[`L2_SET_INDEX_WIDTH - 1:0];
	assign request_tag = request.address[`L2_ADDR_WIDTH - 1:`L2_SET_INDEX_WIDTH];
	assign fill_en = request.valid && request.has_fill && !stall;

	always_comb
	begin
		tag_present = 1'b0;
		for (int way = 0; way < `L2_NUM_WAYS; way++)
		begin
			if (valid_mem[request_set][way] && tag_mem[request_set][way] == request_tag)
				tag_present = 1'b1;
		end
	end

	// Fills go to the way named by the set pointer, which then moves on by one
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int set = 0; set < `L2_NUM_SETS; set++)
			begin
				tag_mem[set] <= '0;
				valid_mem[set] <= '0;
				replace_ptr[set] <= '0;
			end
		end
		else if (fill_en)
		begin
			tag_mem[request_set][replace_ptr[request_set]] <= request_tag;
			valid_mem[request_set][replace_ptr[request_set]] <= 1'b1;
			replace_ptr[request_set] <= replace_ptr[request_set] + 1'b1;
		end
	end

	// The set is sampled before this request's own fill lands in the array.
	// The next request reads the array after the write and so sees it
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tag_out.request.valid <= 1'b0;
		end
		else if (!stall)
		begin
			tag_out.request <= request;
			tag_out.way_tags <= tag_mem[request_set];
			tag_out.way_valid <= valid_mem[request_set];
			tag_out.replace_way <= replace_ptr[request_set];
		end
	end

	// A fill only follows a miss, so its tag must not be resident already.
	// A duplicate here would show up as two matching ways in the directory stage
	assert property (@(posedge clk) disable iff (reset)
		fill_en |-> !tag_present)
		else $error("fill for tag %h already present in set %0d", request_tag, request_set);

endmodule

`default_nettype wire

//--- l2_cache_dir.sv
// L2 directory stage: hit detection, per-line dirty bits and the L1 directory
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_params.svh"

module l2_cache_dir (
	input logic clk,
	input logic reset,
	input logic stall,
	input l2_dir_pkg::tag_stage_t tag_in,
	output l2_dir_pkg::dir_stage_t dir_out
);

	// Dirty bits for all ways of a set, and one L1 entry per {way, set}
	logic [`L2_NUM_WAYS - 1:0] dirty_mem [`L2_NUM_SETS];
	l2_dir_pkg::l1_dir_entry_t l1_dir_mem [`L2_NUM_WAYS][`L2_NUM_SETS];

	l2_dir_pkg::l2_tag_t request_tag;
	l2_dir_pkg::l2_set_t request_set;
	l2_dir_pkg::l1_tag_t request_l1_tag;
	logic [`L2_NUM_WAYS - 1:0] hit_vec;
	logic cache_hit;
	l2_dir_pkg::l2_way_t hit_way;
	l2_dir_pkg::l2_way_t access_way;
	logic is_load;
	logic is_store;
	logic update_en;

	assign request_tag = tag_in.request.address[`L2_ADDR_WIDTH - 1:`L2_SET_INDEX_WIDTH];
	assign request_set = tag_in.request.address[`L2_SET_INDEX_WIDTH - 1:0];
	assign request_l1_tag = tag_in.request.address[`L2_ADDR_WIDTH - 1:`L1_SET_INDEX_WIDTH];

	assign is_load = tag_in.request.op == l2_request_pkg::pci_load
		|| tag_in.request.op == l2_request_pkg::pci_load_sync;
	assign is_store = tag_in.request.op == l2_request_pkg::pci_store
		|| tag_in.request.op == l2_request_pkg::pci_store_sync;

	always_comb
	begin
		hit_way = '0;
		for (int way = 0; way < `L2_NUM_WAYS; way++)
		begin
			hit_vec[way] = tag_in.way_valid[way] && tag_in.way_tags[way] == request_tag;
			if (hit_vec[way])
				hit_way = l2_dir_pkg::l2_way_t'(way);
		end
	end

	assign cache_hit = |hit_vec;

	// A fill lands in the replacement way, which then acts as the hit way
	assign access_way = tag_in.request.has_fill ? tag_in.replace_way : hit_way;

	// Only lines that are resident after this request get their state touched
	assign update_en = !stall && tag_in.request.valid
		&& (cache_hit || tag_in.request.has_fill);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int set = 0; set < `L2_NUM_SETS; set++)
			begin
				dirty_mem[set] <= '0;
				for (int way = 0; way < `L2_NUM_WAYS; way++)
					l1_dir_mem[way][set] <= '0;
			end
		end
		else if (update_en)
		begin
			if (is_store)
				dirty_mem[request_set][access_way] <= 1'b1;
			else if (is_load && tag_in.request.has_fill)
				dirty_mem[request_set][access_way] <= 1'b0;

			// The line is about to be pushed into the L1, so remember where it goes
			if (is_load)
			begin
				l1_dir_mem[access_way][request_set] <= '{
					valid: 1'b1,
					way: tag_in.request.l1_way,
					tag: request_l1_tag
				};
			end
		end
	end

	// Dirty bits and the L1 entry are read before this request's write
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dir_out.request.valid <= 1'b0;
		end
		else if (!stall)
		begin
			dir_out.request <= tag_in.request;
			dir_out.hit <= cache_hit;
			dir_out.hit_way <= access_way;
			dir_out.replace_way <= tag_in.replace_way;
			dir_out.replace_tag <= tag_in.way_tags[tag_in.replace_way];
			dir_out.replace_valid <= tag_in.way_valid[tag_in.replace_way];
			dir_out.dirty <= dirty_mem[request_set];
			dir_out.l1_entry <= l1_dir_mem[access_way][request_set];
		end
	end

	// The tag stage never installs a duplicate tag, so at most one way can match
	assert property (@(posedge clk) disable iff (reset)
		tag_in.request.valid |-> $onehot0(hit_vec))
		else $error("multiple ways hit in set %0d: %b", request_set, hit_vec);

endmodule

`default_nettype wire

//--- l2_cache_response.sv
// L2 response stage: response, dirty-line writeback and L1 update notice
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_params.svh"

module l2_cache_response (
	input logic clk,
	input logic reset,
	input logic stall,
	input l2_dir_pkg::dir_stage_t dir_in,
	output l2_request_pkg::l2_response_t response,
	output l2_request_pkg::writeback_t writeback,
	output l2_request_pkg::l1_update_t l1_update
);

	l2_dir_pkg::l2_set_t request_set;
	logic is_store;
	logic evict_dirty;
	logic need_writeback;
	logic need_l1_update;

	assign request_set = dir_in.request.address[`L2_SET_INDEX_WIDTH - 1:0];
	assign is_store = dir_in.request.op == l2_request_pkg::pci_store
		|| dir_in.request.op == l2_request_pkg::pci_store_sync;

	// A fill pushes out whatever was in the replacement way
	assign evict_dirty = dir_in.replace_valid && dir_in.dirty[dir_in.replace_way];
	assign need_writeback = dir_in.request.valid && dir_in.request.has_fill && evict_dirty;

	// The L1 holds a copy of the line only if its directory entry is valid
	assign need_l1_update = dir_in.request.valid && is_store && dir_in.hit
		&& dir_in.l1_entry.valid;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			response.valid <= 1'b0;
			writeback.valid <= 1'b0;
			l1_update.valid <= 1'b0;
		end
		else if (!stall)
		begin
			response.valid <= dir_in.request.valid;
			response.unit <= dir_in.request.unit;
			response.strand <= dir_in.request.strand;
			response.op <= dir_in.request.op;
			response.hit <= dir_in.hit;
			response.way <= dir_in.hit_way;

			writeback.valid <= need_writeback;
			writeback.address <= {dir_in.replace_tag, request_set};

			l1_update.valid <= need_l1_update;
			l1_update.l1_way <= dir_in.l1_entry.way;
			l1_update.l1_tag <= dir_in.l1_entry.tag;
		end
	end

	// Writebacks only come from fills, and a fill is never reported as a hit
	assert property (@(posedge clk) disable iff (reset)
		writeback.valid |-> response.valid && !response.hit)
		else $error("writeback without a matching fill response");

endmodule

`default_nettype wire

//--- l2_cache_top.sv
// L2 cache slice top level chaining the tag, directory and response stages
`timescale 1ns/1ps
`default_nettype none

module l2_cache_top (
	input logic clk,
	input logic reset,
	input logic stall,
	input l2_request_pkg::l2_request_t request,
	output l2_request_pkg::l2_response_t response,
	output l2_request_pkg::writeback_t writeback,
	output l2_request_pkg::l1_update_t l1_update
);

	l2_dir_pkg::tag_stage_t tag_stage;
	l2_dir_pkg::dir_stage_t dir_stage;

	// Tag lookup, replacement choice and fill install
	l2_cache_tag tag (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.request(request),
		.tag_out(tag_stage)
	);

	// Hit way, dirty bits and L1 directory
	l2_cache_dir dir (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.tag_in(tag_stage),
		.dir_out(dir_stage)
	);

	// Response, writeback and L1 update decisions
	l2_cache_response resp (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.dir_in(dir_stage),
		.response(response),
		.writeback(writeback),
		.l1_update(l1_update)
	);

endmodule

`default_nettype wire

//--- l2_cache_tb.sv
// Testbench for the L2 cache slice: vector file reader, stall injection and output checks
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb;

	typedef struct packed
	{
		l2_request_pkg::l2_response_t response;
		l2_request_pkg::writeback_t writeback;
		l2_request_pkg::l1_update_t l1_update;
	} outputs_t;

	typedef struct packed
	{
		logic stall_flag;
		l2_request_pkg::l2_request_t request;
		outputs_t expected;
	} vector_t;

	logic clk = 1'b0;
	logic reset;
	logic stall;
	l2_request_pkg::l2_request_t request;
	l2_request_pkg::l2_response_t response;
	l2_request_pkg::writeback_t writeback;
	l2_request_pkg::l1_update_t l1_update;

	vector_t vectors[$];
	outputs_t pending[$];
	outputs_t current;
	outputs_t held;
	int response_errors = 0;
	int writeback_errors = 0;
	int update_errors = 0;
	int cycle_count = 0;
	int cycle_limit = 50;
	int extra_stalls;
	int seed_value;

	l2_cache_top UUT (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.request(request),
		.response(response),
		.writeback(writeback),
		.l1_update(l1_update)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	// An invalid expectation only requires the valid bit to be low
	task automatic check_response(input l2_request_pkg::l2_response_t actual,
		input l2_request_pkg::l2_response_t expected);
		if (expected.valid ? actual !== expected : actual.valid !== 1'b0)
		begin
			response_errors++;
			$display("FAIL at %0t ns: response %h (valid %b hit %b way %0d), expected %h",
				$time, actual, actual.valid, actual.hit, actual.way, expected);
		end
	endtask

	task automatic check_writeback(input l2_request_pkg::writeback_t actual,
		input l2_request_pkg::writeback_t expected);
		if (expected.valid ? actual !== expected : actual.valid !== 1'b0)
		begin
			writeback_errors++;
			$display("FAIL at %0t ns: writeback valid %b address %h, expected valid %b address %h",
				$time, actual.valid, actual.address, expected.valid, expected.address);
		end
	endtask

	task automatic check_l1_update(input l2_request_pkg::l1_update_t actual,
		input l2_request_pkg::l1_update_t expected);
		if (expected.valid ? actual !== expected : actual.valid !== 1'b0)
		begin
			update_errors++;
			$display("FAIL at %0t ns: l1 update valid %b way %0d tag %h, expected %b %0d %h",
				$time, actual.valid, actual.l1_way, actual.l1_tag,
				expected.valid, expected.l1_way, expected.l1_tag);
		end
	endtask

	task automatic check_outputs(input outputs_t expected);
		check_response(response, expected.response);
		check_writeback(writeback, expected.writeback);
		check_l1_update(l1_update, expected.l1_update);
	endtask

	// One clock edge. Outputs must hold while stalled, otherwise the pipeline moves by one
	task automatic run_cycle();
		outputs_t popped;
		@(posedge clk);
		#1;
		if (stall)
		begin
			check_outputs(held);
		end
		else
		begin
			pending.push_back(current);
			popped = pending.pop_front();
			check_outputs(popped);
			held = popped;
		end
	endtask

	task automatic load_vectors();
		int fd;
		int got;
		int fields;
		int col [14];
		string line;
		vector_t v;
		fd = $fopen("l2_cache_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("could not open l2_cache_testdata.txt for reading");
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				got = $fgets(line, fd);
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					col[0], col[1], col[2], col[3], col[4], col[5], col[6],
					col[7], col[8], col[9], col[10], col[11], col[12], col[13]);
				// Comment and blank lines never parse as a full vector
				if (got > 0 && fields == 14)
				begin
					v = '0;
					v.stall_flag = col[0] != 0;
					v.request.valid = 1'b1;
					v.request.unit = col[1][1:0];
					v.request.strand = col[2][1:0];
					v.request.op = l2_request_pkg::pci_op_t'(col[3][2:0]);
					v.request.l1_way = col[4][1:0];
					v.request.has_fill = col[5] != 0;
					v.request.address = col[6][25:0];
					// A response echoes the unit, strand and op of its request
					v.expected.response.valid = 1'b1;
					v.expected.response.unit = v.request.unit;
					v.expected.response.strand = v.request.strand;
					v.expected.response.op = v.request.op;
					v.expected.response.hit = col[7] != 0;
					v.expected.response.way = col[8][1:0];
					v.expected.writeback.valid = col[9] != 0;
					v.expected.writeback.address = col[10][25:0];
					v.expected.l1_update.valid = col[11] != 0;
					v.expected.l1_update.l1_way = col[12][1:0];
					v.expected.l1_update.l1_tag = col[13][19:0];
					vectors.push_back(v);
				end
			end
			$fclose(fd);
		end
	endtask

	initial
	begin
		seed_value = $urandom(32'hfe9b);
		reset = 1'b1;
		stall = 1'b0;
		request = '0;
		current = '0;
		held = '0;
		load_vectors();
		cycle_limit = 4 * vectors.size() + 50;
		if (vectors.size() == 0)
		begin
			$display("no test vectors were read, so nothing was run");
			$display("TEST FAIL");
			$finish;
		end
		else
		begin
			repeat (2) @(posedge clk);
			#1;
			reset = 1'b0;
			check_outputs(held);
			// Two bubbles stand for the cleared tag and directory stage registers
			pending.push_back(current);
			pending.push_back(current);
			foreach (vectors[i])
			begin
				extra_stalls = vectors[i].stall_flag + ($urandom % 4 == 0);
				request = vectors[i].request;
				current = vectors[i].expected;
				stall = extra_stalls != 0;
				repeat (extra_stalls) run_cycle();
				stall = 1'b0;
				run_cycle();
			end
			request = '0;
			current = '0;
			repeat (3) run_cycle();
			$display("errors: %0d response, %0d writeback, %0d l1 update",
				response_errors, writeback_errors, update_errors);
			if (response_errors + writeback_errors + update_errors == 0)
				$display("TEST PASS");
			else
				$display("TEST FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- l2_cache_testdata.txt
# stall unit strand op l1_way fill address | hit way wb_valid wb_address upd_valid upd_way upd_tag
# All columns hex. stall=1 holds the request under stall for a cycle before it is taken
0 0 0 0 0 0 0000102 0 0 0 0000000 0 0 00000
0 1 0 0 1 1 0000102 0 0 0 0000000 0 0 00000
1 2 1 1 0 1 0000202 0 1 0 0000000 0 0 00000
0 0 2 0 2 1 0000302 0 2 0 0000000 0 0 00000
0 3 3 4 3 1 0000402 0 3 0 0000000 0 0 00000
0 0 1 0 0 0 0000102 1 0 0 0000000 0 0 00000
1 1 1 1 0 0 0000102 1 0 0 0000000 1 0 00004
0 2 0 0 2 0 0000202 1 1 0 0000000 0 0 00000
0 0 3 0 3 1 0000502 0 0 1 0000102 0 0 00000
1 3 2 4 1 1 0000602 0 1 1 0000202 0 0 00000
0 1 0 1 0 1 0000702 0 2 0 0000000 0 0 00000
0 2 2 5 0 0 0000502 1 0 0 0000000 1 3 00014
1 0 0 1 0 0 0000805 0 0 0 0000000 0 0 00000

//--- sources.f
+incdir+.
l2_request_pkg.sv
l2_dir_pkg.sv
l2_cache_tag.sv
l2_cache_dir.sv
l2_cache_response.sv
l2_cache_top.sv
l2_cache_tb.sv

//--- Bender.yml
package:
  name: l2_cache

sources:
  - include_dirs:
      - .
    files:
      - l2_request_pkg.sv
      - l2_dir_pkg.sv
      - l2_cache_tag.sv
      - l2_cache_dir.sv
      - l2_cache_response.sv
      - l2_cache_top.sv
  - target: test
    files:
      - l2_cache_tb.sv
